// ==== source/ibi_pkg.sv ====
package ibi_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int REGF_ADDR_W = 12;                // Register file address
    localparam int MODE_W      = 3;                 // Tx and rx mode codes
    localparam int TGT_ADDR_W  = 8;                 // Target address byte
    localparam int DYN_ADDR_W  = TGT_ADDR_W - 1;    // Dynamic address in bits 7:1
    localparam int CFG_REG_W   = 8;                 // Config and BCR registers
    localparam int STATE_W     = 3;

    ////////////////////////////////////////
    // Serializer / deserializer mode codes
    ////////////////////////////////////////
    localparam logic [MODE_W-1:0] TX_MODE_SERIAL    = 3'd1;
    localparam logic [MODE_W-1:0] TX_MODE_STOP      = 3'd2;
    localparam logic [MODE_W-1:0] TX_MODE_DRIVE_LOW = 3'd4;   // Open-drain ACK
    localparam logic [MODE_W-1:0] RX_MODE_DESER     = 3'd1;

    ////////////////////////////////////////
    // Register file map
    ////////////////////////////////////////
    // Lowest dynamic address handed out to a target
    localparam logic [DYN_ADDR_W-1:0]  FIRST_TGT_ADDRESS = 7'h08;

    // Per-target records of 8 words, BCR at word 6
    localparam logic [REGF_ADDR_W-1:0] BCR_BASE_ADDRESS  = 12'd200;
    localparam logic [REGF_ADDR_W-1:0] BCR_OFFSET        = 12'd6;
    localparam int                     TGT_STRIDE_SHIFT  = 3;

    localparam logic [REGF_ADDR_W-1:0] MDB_ADDRESS       = 12'd107;

    ////////////////////////////////////////
    // Bit positions
    ////////////////////////////////////////
    localparam int CFG_CTRL_ACK_BIT = 0;    // 1 = ACK, 0 = NACK
    localparam int CFG_PAYLOAD_BIT  = 1;    // 1 = read payload, 0 = stop after MDB
    localparam int BCR_MDB_BIT      = 2;    // MDB follows the IBI

    ////////////////////////////////////////
    // IBI FSM state codes
    ////////////////////////////////////////
    localparam logic [STATE_W-1:0] ST_IDLE      = 3'd0;
    localparam logic [STATE_W-1:0] ST_ACK       = 3'd1;
    localparam logic [STATE_W-1:0] ST_NACK      = 3'd2;
    localparam logic [STATE_W-1:0] ST_MDB       = 3'd3;
    localparam logic [STATE_W-1:0] ST_MDB_T_BIT = 3'd4;
    localparam logic [STATE_W-1:0] ST_PAYLOAD   = 3'd5;
    localparam logic [STATE_W-1:0] ST_STOP      = 3'd6;

endpackage

// ==== source/ibi_ctrl_fsm.sv ====
module ibi_ctrl_fsm (
    input  logic                         i_ibi_clk,
    input  logic                         i_ibi_rst_n,
    input  logic                         i_ibi_en,
    input  logic                         i_ibi_scl,
    input  logic                         i_ibi_scl_neg_edge,
    input  logic                         i_ibi_rx_mode_done,
    input  logic                         i_ibi_ser_mode_done,
    input  logic                         i_ibi_payload_done,
    input  logic [ibi_pkg::CFG_REG_W-1:0] i_ibi_cfg_reg,
    input  logic [ibi_pkg::CFG_REG_W-1:0] i_ibi_bcr_reg,
    output logic                         o_ibi_pp_od,
    output logic                         o_ibi_tx_en,
    output logic                         o_ibi_rx_en,
    output logic                         o_ibi_cnt_en,
    output logic                         o_ibi_payload_en,
    output logic                         o_ibi_ser_rx_tx,
    output logic                         o_ibi_done,
    output logic [ibi_pkg::MODE_W-1:0]   o_ibi_tx_mode,
    output logic [ibi_pkg::MODE_W-1:0]   o_ibi_rx_mode,
    output logic                         o_load_bcr_addr,
    output logic                         o_load_mdb_addr,
    output logic                         o_rd_req,
    output logic                         o_wr_req
);

    import ibi_pkg::*;

    logic [STATE_W-1:0] state;
    logic               rx_done_d1;      // First delayed copy of rx_mode_done
    logic               rx_done_d2;      // Second delayed copy
    logic               rx_done_seen;    // MDB byte in, waiting for SCL low

    ////////////////////////////////////////
    // Receive-done delay line
    ////////////////////////////////////////
    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
        begin
            rx_done_d1 <= 1'b0;
            rx_done_d2 <= 1'b0;
        end
        else
        begin
            rx_done_d1 <= i_ibi_rx_mode_done;
            rx_done_d2 <= rx_done_d1;
        end
    end

    // The second copy steers the port address to the MDB slot in the same
    // cycle that the write pulse is generated
    assign o_load_mdb_addr = (state == ST_MDB) && rx_done_d2;

    ////////////////////////////////////////
    // Main IBI state machine
    ////////////////////////////////////////
    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
        begin
            state            <= ST_IDLE;
            o_ibi_pp_od      <= 1'b0;
            o_ibi_tx_en      <= 1'b0;
            o_ibi_rx_en      <= 1'b0;
            o_ibi_cnt_en     <= 1'b0;
            o_ibi_payload_en <= 1'b0;
            o_ibi_ser_rx_tx  <= 1'b0;
            o_ibi_done       <= 1'b0;
            o_ibi_tx_mode    <= '0;
            o_ibi_rx_mode    <= '0;
            o_load_bcr_addr  <= 1'b0;
            o_rd_req         <= 1'b0;
            o_wr_req         <= 1'b0;
            rx_done_seen     <= 1'b0;
        end
        else
        begin
            o_ibi_done      <= 1'b0;    // Single-cycle pulse
            o_load_bcr_addr <= 1'b0;

            case (state)
                ST_IDLE:
                begin
                    if (i_ibi_en)
                    begin
                        if (i_ibi_cfg_reg[CFG_CTRL_ACK_BIT])
                        begin
                            // Look up the target's BCR once per IBI
                            o_load_bcr_addr <= ~o_rd_req;
                            o_rd_req        <= 1'b1;
                            if (i_ibi_scl_neg_edge)
                            begin
                                state         <= ST_ACK;
                                o_ibi_tx_en   <= 1'b1;
                                o_ibi_tx_mode <= TX_MODE_DRIVE_LOW;
                                o_ibi_pp_od   <= 1'b0;    // ACK is open drain
                            end
                        end
                        else if (i_ibi_scl_neg_edge)
                        begin
                            state       <= ST_NACK;    // SDA left released
                            o_ibi_tx_en <= 1'b0;
                            o_ibi_pp_od <= 1'b0;
                        end
                    end
                    else
                    begin
                        o_ibi_tx_en <= 1'b0;
                        o_rd_req    <= 1'b0;
                    end
                end

                ST_ACK:
                begin
                    // ACK bit is held through the SCL low phase
                    if (i_ibi_scl)
                    begin
                        o_rd_req <= 1'b0;
                        if (i_ibi_bcr_reg[BCR_MDB_BIT])
                        begin
                            state         <= ST_MDB;
                            o_ibi_tx_en   <= 1'b0;
                            o_ibi_rx_en   <= 1'b1;
                            o_ibi_cnt_en  <= 1'b1;
                            o_ibi_pp_od   <= 1'b1;
                            o_ibi_rx_mode <= RX_MODE_DESER;
                        end
                        else
                        begin
                            state <= ST_STOP;
                        end
                    end
                end

                ST_NACK:
                begin
                    if (i_ibi_scl)
                    begin
                        state <= ST_STOP;
                    end
                end

                ST_MDB:
                begin
                    if (rx_done_d1)
                    begin
                        o_wr_req <= 1'b1;    // Port turns this edge into wr_en
                    end
                    if (rx_done_d2)
                    begin
                        rx_done_seen <= 1'b1;
                    end
                    // Byte in hand, leave on the low phase for the T-bit
                    if ((rx_done_d2 || rx_done_seen) && !i_ibi_scl)
                    begin
                        state         <= ST_MDB_T_BIT;
                        rx_done_seen  <= 1'b0;
                        o_ibi_rx_en   <= 1'b0;
                        o_ibi_cnt_en  <= 1'b0;
                        o_ibi_tx_mode <= TX_MODE_DRIVE_LOW;
                    end
                end

                ST_MDB_T_BIT:
                begin
                    o_wr_req <= 1'b0;
                    if (i_ibi_cfg_reg[CFG_PAYLOAD_BIT])
                    begin
                        // Hand the bus over to the payload reader
                        state            <= ST_PAYLOAD;
                        o_ibi_payload_en <= 1'b1;
                        o_ibi_ser_rx_tx  <= 1'b1;
                    end
                    else if (i_ibi_scl)
                    begin
                        state         <= ST_STOP;
                        o_ibi_tx_en   <= 1'b1;
                        o_ibi_tx_mode <= TX_MODE_DRIVE_LOW;
                    end
                end

                ST_PAYLOAD:
                begin
                    if (i_ibi_payload_done)
                    begin
                        state            <= ST_IDLE;
                        o_ibi_payload_en <= 1'b0;
                        o_ibi_ser_rx_tx  <= 1'b0;
                        o_ibi_pp_od      <= 1'b0;
                        o_ibi_done       <= 1'b1;
                    end
                end

                ST_STOP:
                begin
                    if (!i_ibi_scl)
                    begin
                        o_ibi_tx_en   <= 1'b1;
                        o_ibi_tx_mode <= TX_MODE_STOP;
                    end
                    else if (i_ibi_ser_mode_done)
                    begin
                        state       <= ST_IDLE;    // STOP is on the bus
                        o_ibi_tx_en <= 1'b0;
                        o_ibi_pp_od <= 1'b0;
                        o_ibi_done  <= 1'b1;
                    end
                end

                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== source/ibi_regf_port.sv ====
module ibi_regf_port (
    input  logic                           i_ibi_clk,
    input  logic                           i_ibi_rst_n,
    input  logic [ibi_pkg::TGT_ADDR_W-1:0]  i_ibi_tgt_address,
    input  logic                           i_load_bcr_addr,
    input  logic                           i_load_mdb_addr,
    input  logic                           i_rd_req,
    input  logic                           i_wr_req,
    output logic [ibi_pkg::REGF_ADDR_W-1:0] o_ibi_regf_address,
    output logic                           o_ibi_regf_rd_en,
    output logic                           o_ibi_regf_wr_en
);

    import ibi_pkg::*;

    logic [DYN_ADDR_W-1:0]  tgt_index;    // Position of the target's record
    logic [REGF_ADDR_W-1:0] bcr_addr;
    logic                   wr_req_q;

    ////////////////////////////////////////
    // BCR address lookup
    ////////////////////////////////////////
    assign tgt_index = i_ibi_tgt_address[TGT_ADDR_W-1:1] - FIRST_TGT_ADDRESS;
    assign bcr_addr  = (REGF_ADDR_W'(tgt_index) << TGT_STRIDE_SHIFT)
                     + BCR_OFFSET + BCR_BASE_ADDRESS;

    ////////////////////////////////////////
    // Address register and read enable
    ////////////////////////////////////////
    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
        begin
            o_ibi_regf_address <= '0;
            o_ibi_regf_rd_en   <= 1'b0;
        end
        else
        begin
            if (i_load_mdb_addr)
            begin
                o_ibi_regf_address <= MDB_ADDRESS;
            end
            else if (i_load_bcr_addr)
            begin
                o_ibi_regf_address <= bcr_addr;
            end
            o_ibi_regf_rd_en <= i_rd_req;
        end
    end

    ////////////////////////////////////////
    // Write pulse from the request's rising edge
    ////////////////////////////////////////
    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
        begin
            wr_req_q         <= 1'b0;
            o_ibi_regf_wr_en <= 1'b0;
        end
        else
        begin
            wr_req_q         <= i_wr_req;
            o_ibi_regf_wr_en <= i_wr_req & ~wr_req_q;    // One cycle per request
        end
    end

endmodule

// ==== source/ibi_top.sv ====
module ibi_top (
    input  logic                           i_ibi_clk,
    input  logic                           i_ibi_rst_n,
    input  logic                           i_ibi_en,
    input  logic                           i_ibi_scl,
    input  logic                           i_ibi_scl_neg_edge,
    input  logic                           i_ibi_rx_mode_done,
    input  logic                           i_ibi_ser_mode_done,
    input  logic                           i_ibi_payload_done,
    input  logic [ibi_pkg::CFG_REG_W-1:0]   i_ibi_cfg_reg,
    input  logic [ibi_pkg::CFG_REG_W-1:0]   i_ibi_bcr_reg,
    input  logic [ibi_pkg::TGT_ADDR_W-1:0]  i_ibi_tgt_address,
    output logic                           o_ibi_pp_od,
    output logic                           o_ibi_tx_en,
    output logic                           o_ibi_rx_en,
    output logic                           o_ibi_cnt_en,
    output logic                           o_ibi_payload_en,
    output logic                           o_ibi_ser_rx_tx,
    output logic                           o_ibi_done,
    output logic [ibi_pkg::MODE_W-1:0]      o_ibi_tx_mode,
    output logic [ibi_pkg::MODE_W-1:0]      o_ibi_rx_mode,
    output logic [ibi_pkg::REGF_ADDR_W-1:0] o_ibi_regf_address,
    output logic                           o_ibi_regf_rd_en,
    output logic                           o_ibi_regf_wr_en
);

    // FSM requests toward the register file
    logic load_bcr_addr;
    logic load_mdb_addr;
    logic rd_req;
    logic wr_req;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////
    ibi_ctrl_fsm u_fsm (
        .i_ibi_clk           (i_ibi_clk),
        .i_ibi_rst_n         (i_ibi_rst_n),
        .i_ibi_en            (i_ibi_en),
        .i_ibi_scl           (i_ibi_scl),
        .i_ibi_scl_neg_edge  (i_ibi_scl_neg_edge),
        .i_ibi_rx_mode_done  (i_ibi_rx_mode_done),
        .i_ibi_ser_mode_done (i_ibi_ser_mode_done),
        .i_ibi_payload_done  (i_ibi_payload_done),
        .i_ibi_cfg_reg       (i_ibi_cfg_reg),
        .i_ibi_bcr_reg       (i_ibi_bcr_reg),
        .o_ibi_pp_od         (o_ibi_pp_od),
        .o_ibi_tx_en         (o_ibi_tx_en),
        .o_ibi_rx_en         (o_ibi_rx_en),
        .o_ibi_cnt_en        (o_ibi_cnt_en),
        .o_ibi_payload_en    (o_ibi_payload_en),
        .o_ibi_ser_rx_tx     (o_ibi_ser_rx_tx),
        .o_ibi_done          (o_ibi_done),
        .o_ibi_tx_mode       (o_ibi_tx_mode),
        .o_ibi_rx_mode       (o_ibi_rx_mode),
        .o_load_bcr_addr     (load_bcr_addr),
        .o_load_mdb_addr     (load_mdb_addr),
        .o_rd_req            (rd_req),
        .o_wr_req            (wr_req)
    );

    ////////////////////////////////////////
    // Register file side
    ////////////////////////////////////////
    ibi_regf_port u_regf_port (
        .i_ibi_clk          (i_ibi_clk),
        .i_ibi_rst_n        (i_ibi_rst_n),
        .i_ibi_tgt_address  (i_ibi_tgt_address),
        .i_load_bcr_addr    (load_bcr_addr),
        .i_load_mdb_addr    (load_mdb_addr),
        .i_rd_req           (rd_req),
        .i_wr_req           (wr_req),
        .o_ibi_regf_address (o_ibi_regf_address),
        .o_ibi_regf_rd_en   (o_ibi_regf_rd_en),
        .o_ibi_regf_wr_en   (o_ibi_regf_wr_en)
    );

endmodule

// ==== verification/ibi_tb_props.sv ====
module ibi_tb_props (
    input logic                            i_ibi_clk,
    input logic                            i_ibi_rst_n,
    input logic                            i_ibi_regf_wr_en,
    input logic                            i_ibi_done,
    input logic [ibi_pkg::REGF_ADDR_W-1:0] i_ibi_regf_address
);

    import ibi_pkg::*;

    ////////////////////////////////////////
    // Pulse widths
    ////////////////////////////////////////
    wr_en_single: assert property (@(posedge i_ibi_clk) disable iff (!i_ibi_rst_n)
        i_ibi_regf_wr_en |=> !i_ibi_regf_wr_en)
        else $error("regf write enable high for two cycles in a row");

    done_single: assert property (@(posedge i_ibi_clk) disable iff (!i_ibi_rst_n)
        i_ibi_done |=> !i_ibi_done)
        else $error("done high for two cycles in a row");

    // MDB is the only word this block ever writes
    wr_at_mdb: assert property (@(posedge i_ibi_clk) disable iff (!i_ibi_rst_n)
        i_ibi_regf_wr_en |-> (i_ibi_regf_address == MDB_ADDRESS))
        else $error("regf write at address %0d instead of the MDB slot", i_ibi_regf_address);

endmodule

bind ibi_top ibi_tb_props u_props (
    .i_ibi_clk          (i_ibi_clk),
    .i_ibi_rst_n        (i_ibi_rst_n),
    .i_ibi_regf_wr_en   (o_ibi_regf_wr_en),
    .i_ibi_done         (o_ibi_done),
    .i_ibi_regf_address (o_ibi_regf_address)
);

// ==== verification/ibi_tb.sv ====
module ibi_tb;

    import ibi_pkg::*;

    localparam int          CLK_PERIOD  = 20;
    localparam int          DRIVE_DLY   = 2;
    localparam int          SCL_HALF    = 8;      // Clocks per SCL phase
    localparam int          N_FIXED     = 5;
    localparam int          N_ROWS      = N_FIXED + 8;
    localparam int          WAIT_LIMIT  = 300;    // Clocks allowed for one IBI
    localparam int          TEST_BUDGET = 400;
    localparam logic [31:0] SEED        = 32'h8886_b09b;

    typedef struct packed {
        logic [CFG_REG_W-1:0]   cfg;
        logic [CFG_REG_W-1:0]   bcr;
        logic [TGT_ADDR_W-1:0]  tgt;
        logic                   ack;
        logic                   mdb;
        logic                   payload;
        logic [REGF_ADDR_W-1:0] addr;     // Expected BCR address
    } row_t;

    logic                   ibi_clk, ibi_rst_n, ibi_en, scl, scl_neg_edge;
    logic                   rx_mode_done, ser_mode_done, payload_done;
    logic [CFG_REG_W-1:0]   cfg_reg, bcr_reg;
    logic [TGT_ADDR_W-1:0]  tgt_address;
    logic                   pp_od, tx_en, rx_en, cnt_en, payload_en, ser_rx_tx, done;
    logic                   regf_rd_en, regf_wr_en;
    logic [MODE_W-1:0]      tx_mode, rx_mode;
    logic [REGF_ADDR_W-1:0] regf_address;
    row_t                   rows[$];
    string                  names[$];
    logic [31:0]            lcg_state;
    int                     mismatches, failures;

    ibi_top i_ibi_top (
        .i_ibi_clk           (ibi_clk),
        .i_ibi_rst_n         (ibi_rst_n),
        .i_ibi_en            (ibi_en),
        .i_ibi_scl           (scl),
        .i_ibi_scl_neg_edge  (scl_neg_edge),
        .i_ibi_rx_mode_done  (rx_mode_done),
        .i_ibi_ser_mode_done (ser_mode_done),
        .i_ibi_payload_done  (payload_done),
        .i_ibi_cfg_reg       (cfg_reg),
        .i_ibi_bcr_reg       (bcr_reg),
        .i_ibi_tgt_address   (tgt_address),
        .o_ibi_pp_od         (pp_od),
        .o_ibi_tx_en         (tx_en),
        .o_ibi_rx_en         (rx_en),
        .o_ibi_cnt_en        (cnt_en),
        .o_ibi_payload_en    (payload_en),
        .o_ibi_ser_rx_tx     (ser_rx_tx),
        .o_ibi_done          (done),
        .o_ibi_tx_mode       (tx_mode),
        .o_ibi_rx_mode       (rx_mode),
        .o_ibi_regf_address  (regf_address),
        .o_ibi_regf_rd_en    (regf_rd_en),
        .o_ibi_regf_wr_en    (regf_wr_en)
    );

    initial
    begin
        ibi_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ibi_clk = ~ibi_clk;
    end

    initial
    begin : watchdog
        #((N_ROWS * TEST_BUDGET + 10) * CLK_PERIOD);
        $display("error: watchdog expired before the IBI tests completed");
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Bus model
    ////////////////////////////////////////
    initial
    begin : bus_model
        int scl_cnt, rx_cnt, pl_cnt;
        {scl, scl_neg_edge, rx_mode_done, ser_mode_done, payload_done} = '0;
        scl_cnt = 0;
        rx_cnt  = 0;
        pl_cnt  = 0;
        forever
        begin
            @(posedge ibi_clk);
            #DRIVE_DLY;
            scl_cnt      = (scl_cnt == SCL_HALF - 1) ? 0 : scl_cnt + 1;
            scl_neg_edge = (scl_cnt == 0) && scl;
            scl          = (scl_cnt == 0) ? ~scl : scl;
            rx_cnt       = rx_en ? rx_cnt + 1 : 0;
            pl_cnt       = payload_en ? pl_cnt + 1 : 0;
            rx_mode_done = (rx_cnt == 6 * SCL_HALF);    // 3 SCL periods
            payload_done = (pl_cnt == 8 * SCL_HALF);    // 4 SCL periods
            // Serializer finishes the STOP in the SCL high phase
            ser_mode_done = tx_en && (tx_mode == TX_MODE_STOP) && scl;
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers and compare tasks
    ////////////////////////////////////////
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Records of 8 words from address 200, BCR at word 6, first target 8
    function automatic logic [REGF_ADDR_W-1:0] expected_bcr_addr(input logic [7:0] tgt);
        return 12'd206 + 12'((tgt[7:1] - 7'd8) * 8);
    endfunction

    task automatic add_row(input string name, input row_t r);
        names.push_back(name);
        rows.push_back(r);
    endtask

    task automatic add_random_row(input int idx);
        logic [31:0] rnd;
        row_t        r;
        rnd       = next_rand();
        r.cfg     = rnd[31:24];
        r.bcr     = rnd[15:8];
        r.tgt     = {7'(8 + rnd[17:16]), rnd[20]};    // Dynamic address 8 to 11
        r.ack     = r.cfg[0];
        r.mdb     = r.ack && r.bcr[2];
        r.payload = r.mdb && r.cfg[1];
        r.addr    = expected_bcr_addr(r.tgt);
        add_row($sformatf("random_%0d", idx), r);
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            mismatches++;
            $display("mismatch %s: expected %0b, actual %0b", what, exp, act);
        end
    endtask

    task automatic check_mode(input string what, input logic [MODE_W-1:0] exp,
                              input logic [MODE_W-1:0] act);
        if (act !== exp)
        begin
            mismatches++;
            $display("mismatch %s: expected %0d, actual %0d", what, exp, act);
        end
    endtask

    task automatic check_addr(input string what, input logic [REGF_ADDR_W-1:0] exp,
                              input logic [REGF_ADDR_W-1:0] act);
        if (act !== exp)
        begin
            mismatches++;
            $display("mismatch %s: expected %0d, actual %0d", what, exp, act);
        end
    endtask

    task automatic check_idle(input string what);
        check_flag({what, " flags"}, 1'b0, |{pp_od, tx_en, rx_en, cnt_en, payload_en,
                                            ser_rx_tx, done, regf_rd_en, regf_wr_en});
        check_mode({what, " tx_mode"}, '0, tx_mode);
        check_mode({what, " rx_mode"}, '0, rx_mode);
        check_addr({what, " address"}, '0, regf_address);
    endtask

    ////////////////////////////////////////
    // One IBI from request to done
    ////////////////////////////////////////
    task automatic run_row(input string name, input row_t r);
        int                     cycles, trail, rd_cycle, wr_count, pl_cycles, done_count;
        logic                   rx_seen, stop_seen, serial_seen, split_seen;
        logic                   cnt_cap, pp_cap;
        logic [REGF_ADDR_W-1:0] rd_addr, wr_addr;
        logic [MODE_W-1:0]      rx_mode_cap;
        {cycles, trail, rd_cycle, wr_count, pl_cycles, done_count} = '0;
        {rx_seen, stop_seen, serial_seen, split_seen, rd_addr, wr_addr, rx_mode_cap} = '0;
        {cnt_cap, pp_cap} = '0;
        @(posedge ibi_clk);
        #DRIVE_DLY;
        cfg_reg     = r.cfg;
        bcr_reg     = r.bcr;
        tgt_address = r.tgt;
        ibi_en      = 1'b1;
        while (cycles < WAIT_LIMIT && trail < 3)    // A few clocks past done
        begin
            @(posedge ibi_clk);
            #DRIVE_DLY;
            cycles++;
            trail += (done_count > 0);
            if (regf_rd_en && rd_cycle == 0)
            begin
                rd_cycle = cycles;
                rd_addr  = regf_address;
            end
            if (rx_en && !rx_seen)
            begin
                rx_seen     = 1'b1;
                rx_mode_cap = rx_mode;
                cnt_cap     = cnt_en;
                pp_cap      = pp_od;
            end
            if (regf_wr_en)
            begin
                wr_count++;
                wr_addr = regf_address;
            end
            stop_seen   |= tx_en && (tx_mode == TX_MODE_STOP) && (done_count == 0);
            serial_seen |= (tx_mode == TX_MODE_SERIAL);
            split_seen  |= (payload_en != ser_rx_tx);
            pl_cycles   += payload_en;
            if (done)
            begin
                done_count++;
                ibi_en = 1'b0;    // No new request once back in IDLE
            end
        end
        ibi_en = 1'b0;
        if (done_count == 0)
        begin
            failures++;
            $display("error: %s never signalled done within %0d clocks", name, WAIT_LIMIT);
        end
        check_flag({name, " single done"}, 1'b1, done_count == 1);
        check_flag({name, " rd_en"}, r.ack, rd_cycle != 0);
        if (r.ack)
        begin
            check_flag({name, " rd_en two clocks after request"}, 1'b1, rd_cycle == 2);
            check_addr({name, " bcr address"}, r.addr, rd_addr);
        end
        check_flag({name, " rx_en"}, r.mdb, rx_seen);
        check_flag({name, " one write"}, r.mdb, wr_count == 1);
        check_flag({name, " extra write"}, 1'b0, wr_count > 1);
        if (r.mdb)
        begin
            check_mode({name, " rx_mode"}, RX_MODE_DESER, rx_mode_cap);
            check_flag({name, " cnt_en with rx_en"}, 1'b1, cnt_cap);
            check_flag({name, " pp_od with rx_en"}, 1'b1, pp_cap);
            check_addr({name, " write address"}, MDB_ADDRESS, wr_addr);
        end
        check_flag({name, " stop driven"}, !r.payload, stop_seen);
        check_flag({name, " payload_en"}, r.payload, pl_cycles != 0);
        check_flag({name, " payload held"}, r.payload, pl_cycles >= 8 * SCL_HALF);
        check_flag({name, " ser_rx_tx split"}, 1'b0, split_seen);
        check_flag({name, " serial mode"}, 1'b0, serial_seen);
    endtask

    initial
    begin : main
        lcg_state   = SEED;
        mismatches  = 0;
        failures    = 0;
        ibi_rst_n   = 1'b0;
        ibi_en      = 1'b0;
        cfg_reg     = '0;
        bcr_reg     = '0;
        tgt_address = '0;
        // Name, cfg, bcr, target, ack, mdb, payload, BCR address
        add_row("nack",          row_t'{8'h00, 8'h04, 8'h10, 1'b0, 1'b0, 1'b0, 12'd206});
        add_row("ack_no_mdb",    row_t'{8'h01, 8'h00, 8'h12, 1'b1, 1'b0, 1'b0, 12'd214});
        add_row("mdb_stop",      row_t'{8'h01, 8'h04, 8'h14, 1'b1, 1'b1, 1'b0, 12'd222});
        add_row("mdb_payload",   row_t'{8'h03, 8'h04, 8'h17, 1'b1, 1'b1, 1'b1, 12'd230});
        add_row("nack_with_cfg", row_t'{8'h02, 8'h04, 8'h10, 1'b0, 1'b0, 1'b0, 12'd206});
        for (int i = 0; i < N_ROWS - N_FIXED; i++)
        begin
            add_random_row(i);
        end
        repeat (4) @(posedge ibi_clk);
        #DRIVE_DLY;
        check_idle("reset active");
        ibi_rst_n = 1'b1;
        repeat (2) @(posedge ibi_clk);
        #DRIVE_DLY;
        check_idle("after reset");
        for (int i = 0; i < rows.size(); i++)
        begin
            run_row(names[i], rows[i]);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
source/ibi_pkg.sv
source/ibi_ctrl_fsm.sv
source/ibi_regf_port.sv
source/ibi_top.sv
verification/ibi_tb_props.sv
verification/ibi_tb.sv
